/* verilog/datapath_defines.svh */
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// Data word and multiply result widths
`define DP_WORD_WIDTH 32

// Register file geometry
`define DP_REG_COUNT 16
`define DP_REG_ADDR_WIDTH 4

// ALU operation code
`define DP_ALU_OP_WIDTH 4

`endif

/* verilog/wordPkg.sv */
package wordPkg;

`include "datapath_defines.svh"

    // One data word, as held in registers and on the memory bus
    typedef logic [`DP_WORD_WIDTH-1:0] word;

    // Index into the register file
    typedef logic [`DP_REG_ADDR_WIDTH-1:0] regAddr;

    // Full signed multiply result, high word above low word
    typedef logic [2*`DP_WORD_WIDTH-1:0] product;

endpackage

/* verilog/aluPkg.sv */
package aluPkg;

`include "datapath_defines.svh"

    typedef logic [`DP_ALU_OP_WIDTH-1:0] aluOp;

    // Arithmetic
    localparam aluOp opAdd = 4'h0;
    localparam aluOp opSub = 4'h1;

    // Bitwise logic
    localparam aluOp opAnd = 4'h2;
    localparam aluOp opOr = 4'h3;
    localparam aluOp opXor = 4'h4;

    // Shifts and rotates, amount from low bits of b
    localparam aluOp opShl = 4'h5;
    localparam aluOp opShr = 4'h6;
    localparam aluOp opSra = 4'h7;
    localparam aluOp opRol = 4'h8;
    localparam aluOp opRor = 4'h9;

    // Signed multiply, the only op with a nonzero high word
    localparam aluOp opMul = 4'ha;

    // Unary ops on b
    localparam aluOp opNeg = 4'hb;
    localparam aluOp opNot = 4'hc;
    localparam aluOp opPassB = 4'hd;

endpackage

/* verilog/programCounter.sv */
`timescale 1ns/10ps

module programCounter (
    input  logic         Clock,
    input  logic         rst,
    input  logic         clear,
    input  logic         enable,
    input  logic         loadImm,
    input  logic         loadReg,
    input  wordPkg::word imm,
    input  wordPkg::word regValue,
    output wordPkg::word value
);

    import wordPkg::*;

    word nextValue;

    // Immediate load wins over register load, then plain increment
    always_comb begin
        if (loadImm) begin
            nextValue = imm;
        end else if (loadReg) begin
            nextValue = regValue;
        end else begin
            nextValue = value + word'(1);
        end
    end

    // Clear does not need the enable
    always_ff @(posedge Clock) begin
        if (rst || clear) begin
            value <= '0;
        end else if (enable) begin
            value <= nextValue;
        end
    end

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/10ps

module registerFile (
    input  logic            Clock,
    input  logic            rst,
    input  logic            write,
    input  wordPkg::regAddr addrA,
    input  wordPkg::regAddr addrB,
    input  wordPkg::regAddr addrC,
    input  wordPkg::word    writeData,
    output wordPkg::word    readA,
    output wordPkg::word    readB
);

`include "datapath_defines.svh"

    import wordPkg::*;

    // Register 0 is not hardwired, it stores like the others
    word regs [`DP_REG_COUNT];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `DP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[addrC] <= writeData;
        end
    end

    // Asynchronous reads, a write shows up right after its edge
    assign readA = regs[addrA];
    assign readB = regs[addrB];

endmodule

/* verilog/alu.sv */
`timescale 1ns/10ps

module alu (
    input  aluPkg::aluOp  op,
    input  wordPkg::word  a,
    input  wordPkg::word  b,
    output wordPkg::word  low,
    output wordPkg::word  high,
    output logic          zero,
    output logic          negative
);

`include "datapath_defines.svh"

    import wordPkg::*;
    import aluPkg::*;

    localparam int WordWidth = `DP_WORD_WIDTH;
    localparam int ShiftWidth = $clog2(WordWidth);

    logic [ShiftWidth-1:0] shamt;
    product mulResult;
    product rotLeft;
    product rotRight;

    assign shamt = b[ShiftWidth-1:0];

    // Both operands sign extended so the product is a true signed 64-bit result
    assign mulResult = $signed({{WordWidth{a[WordWidth-1]}}, a})
                     * $signed({{WordWidth{b[WordWidth-1]}}, b});

    // Rotates done on a doubled copy of a
    assign rotLeft = {a, a} << shamt;
    assign rotRight = {a, a} >> shamt;

    always_comb begin
        high = '0;
        case (op)
            opAdd: begin
                low = a + b;
            end
            opSub: begin
                low = a - b;
            end
            opAnd: begin
                low = a & b;
            end
            opOr: begin
                low = a | b;
            end
            opXor: begin
                low = a ^ b;
            end
            opShl: begin
                low = a << shamt;
            end
            opShr: begin
                low = a >> shamt;
            end
            opSra: begin
                low = $signed(a) >>> shamt;
            end
            opRol: begin
                // Upper half holds the bits rotated in from the top
                low = rotLeft[2*WordWidth-1:WordWidth];
            end
            opRor: begin
                low = rotRight[WordWidth-1:0];
            end
            opMul: begin
                low = mulResult[WordWidth-1:0];
                high = mulResult[2*WordWidth-1:WordWidth];
            end
            opNeg: begin
                low = '0 - b;
            end
            opNot: begin
                low = ~b;
            end
            opPassB: begin
                low = b;
            end
            default: begin
                low = '0;
            end
        endcase
    end

    // Flags follow the low word only
    assign zero = (low == '0);
    assign negative = low[WordWidth-1];

endmodule

/* verilog/datapath.sv */
`timescale 1ns/10ps

module datapath (
    input  logic            Clock,
    input  logic            rst,
    input  wordPkg::word    memDataIn,
    input  wordPkg::word    imm32,
    output wordPkg::word    memAddr,
    output wordPkg::word    memDataOut,
    input  logic            pcClear,
    input  logic            pcEn,
    input  logic            pcLoadImm,
    input  logic            pcLoadRa,
    input  logic            rfWrite,
    input  wordPkg::regAddr addrA,
    input  wordPkg::regAddr addrB,
    input  wordPkg::regAddr addrC,
    input  aluPkg::aluOp    aluOp,
    input  logic            aEn,
    input  logic            bEn,
    input  logic            highEn,
    input  logic            lowEn,
    input  logic            storeEn,
    input  logic            wbEn,
    input  logic            immSel,
    input  logic            highSel,
    input  logic            memSel,
    input  logic            wbHighSel,
    input  logic            mapSel,
    input  logic            storeSel,
    output logic            zero,
    output logic            negative,
    output logic            brZero,
    output logic            brNonZero,
    output logic            brPositive,
    output logic            brNegative
);

    import wordPkg::*;

    word pcValue;
    word rfReadA;
    word rfReadB;

    // Holding registers around the ALU
    word operandA;
    word operandB;
    word resultHigh;
    word resultLow;
    word storeReg;
    word writeBack;

    word aluA;
    word aluLow;
    word aluHigh;

    programCounter pc (
        .Clock    (Clock),
        .rst      (rst),
        .clear    (pcClear),
        .enable   (pcEn),
        .loadImm  (pcLoadImm),
        .loadReg  (pcLoadRa),
        .imm      (imm32),
        .regValue (operandA),
        .value    (pcValue)
    );

    registerFile rf (
        .Clock     (Clock),
        .rst       (rst),
        .write     (rfWrite),
        .addrA     (addrA),
        .addrB     (addrB),
        .addrC     (addrC),
        .writeData (writeBack),
        .readA     (rfReadA),
        .readB     (rfReadB)
    );

    // Storage register can stand in for operand A
    assign aluA = storeSel ? storeReg : operandA;

    alu aluCore (
        .op       (aluOp),
        .a        (aluA),
        .b        (operandB),
        .low      (aluLow),
        .high     (aluHigh),
        .zero     (zero),
        .negative (negative)
    );

    // Each stage loads on its own strobe, so stages may overlap
    always_ff @(posedge Clock) begin
        if (rst) begin
            operandA <= '0;
            operandB <= '0;
            resultHigh <= '0;
            resultLow <= '0;
            storeReg <= '0;
            writeBack <= '0;
        end else begin
            if (aEn) begin
                operandA <= rfReadA;
            end
            if (bEn) begin
                operandB <= immSel ? imm32 : rfReadB;
            end
            if (highEn) begin
                resultHigh <= highSel ? aluLow : aluHigh;
            end
            if (lowEn) begin
                resultLow <= aluLow;
            end
            if (storeEn) begin
                storeReg <= aluLow;
            end
            if (wbEn) begin
                // Memory data takes precedence over either result word
                if (memSel) begin
                    writeBack <= memDataIn;
                end else begin
                    writeBack <= wbHighSel ? resultHigh : resultLow;
                end
            end
        end
    end

    assign memAddr = mapSel ? pcValue : resultLow;
    assign memDataOut = rfReadB;

    // Branch conditions on read port B
    assign brZero = (rfReadB == '0);
    assign brNonZero = !brZero;
    assign brNegative = rfReadB[$bits(word)-1];
    assign brPositive = !brNegative && !brZero;

endmodule

/* bench/datapath_checker.sv */
`timescale 1ns/10ps

module datapathChecker (
    input logic            Clock,
    input logic            rst,
    input logic            rfWrite,
    input logic            mapSel,
    input logic            pcEn,
    input logic            pcClear,
    input logic            pcLoadImm,
    input logic            pcLoadRa,
    input wordPkg::regAddr addrB,
    input wordPkg::regAddr addrC,
    input wordPkg::word    writeBack,
    input wordPkg::word    memDataOut,
    input wordPkg::word    rfReadA,
    input wordPkg::word    rfReadB,
    input wordPkg::word    memAddr,
    input wordPkg::word    pcValue
);

    // Word written at one edge is what port B returns for that address one cycle later
    writeReadback: assert property (@(posedge Clock) disable iff (rst)
        rfWrite |=> (addrB != $past(addrC)) || (memDataOut == $past(writeBack)))
        else $error("register file read back a word other than the one written");

    // Read ports hold known values once reset has cleared the array
    readPortsKnown: assert property (@(posedge Clock) disable iff (rst)
        !$isunknown({rfReadA, rfReadB}))
        else $error("register file read port is unknown after reset");

    // Fetch address one step past the PC after a plain enabled increment
    pcOnAddress: assert property (@(posedge Clock) disable iff (rst)
        mapSel && $past(pcEn) && !$past(pcClear) && !$past(pcLoadImm) && !$past(pcLoadRa)
        |-> (memAddr == $past(pcValue) + 32'd1))
        else $error("fetch address did not advance by one after a PC increment");

endmodule

/* bench/datapathBench.sv */
`timescale 1ns/10ps

module datapathBench;

`include "datapath_defines.svh"

    import wordPkg::*;
    import aluPkg::*;

    localparam int Period = 8;
    localparam int ResetCycles = 3;
    localparam int RegCount = `DP_REG_COUNT;
    localparam int MemTests = 10;
    localparam int AluTests = 200;
    localparam int MulTests = 20;
    localparam int StoreTests = 20;
    localparam int PcTests = 40;
    localparam int BranchTests = 30;
    // Cycles used by one call of each step sequence
    localparam int LoadCycles = 3;
    localparam int OpCycles = 5;
    localparam int StoreCycles = 6;
    localparam int PcCycles = 3;
    localparam int PlannedCycles = ResetCycles + RegCount + 2
        + (RegCount + MemTests + BranchTests) * LoadCycles
        + (AluTests + MulTests) * OpCycles + StoreTests * StoreCycles
        + (PcTests + 1) * PcCycles + 2;
    localparam int CycleLimit = 2 * PlannedCycles;

    localparam aluOp OpList [14] = '{opAdd, opSub, opAnd, opOr, opXor, opShl, opShr,
                                     opSra, opRol, opRor, opMul, opNeg, opNot, opPassB};

    logic Clock = 1'b0;
    logic rst;
    word memDataIn, imm32, memAddr, memDataOut;
    logic pcClear, pcEn, pcLoadImm, pcLoadRa, rfWrite;
    regAddr addrA, addrB, addrC;
    aluOp opCode;
    logic aEn, bEn, highEn, lowEn, storeEn, wbEn;
    logic immSel, highSel, memSel, wbHighSel, mapSel, storeSel;
    logic zero, negative, brZero, brNonZero, brPositive, brNegative;

    word modelRegs [RegCount];
    word modelPc;
    word rngState = 32'h1daa;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    datapath uut (.aluOp(opCode), .*);

    bind datapath datapathChecker dpCheck (
        .Clock      (Clock),
        .rst        (rst),
        .rfWrite    (rfWrite),
        .mapSel     (mapSel),
        .pcEn       (pcEn),
        .pcClear    (pcClear),
        .pcLoadImm  (pcLoadImm),
        .pcLoadRa   (pcLoadRa),
        .addrB      (addrB),
        .addrC      (addrC),
        .writeBack  (writeBack),
        .memDataOut (memDataOut),
        .rfReadA    (rfReadA),
        .rfReadB    (rfReadB),
        .memAddr    (memAddr),
        .pcValue    (pcValue)
    );

    always #(Period / 2) Clock = ~Clock;

    always @(posedge Clock) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic word nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Reference ALU, high word above low word
    function automatic product modelAlu(input aluOp op, input word a, input word b);
        int s;
        longint p;
        word lo;
        s = int'(b[4:0]);
        p = longint'($signed(a)) * longint'($signed(b));
        case (op)
            opAdd: lo = a + b;
            opSub: lo = a - b;
            opAnd: lo = a & b;
            opOr: lo = a | b;
            opXor: lo = a ^ b;
            opShl: lo = a << s;
            opShr: lo = a >> s;
            opSra: lo = (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
            opRol: lo = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
            opRor: lo = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
            opMul: return product'(p);
            opNeg: lo = -b;
            opNot: lo = ~b;
            opPassB: lo = b;
            default: lo = '0;
        endcase
        return {32'h0, lo};
    endfunction

    task automatic clearStrobes();
        {pcClear, pcEn, pcLoadImm, pcLoadRa, rfWrite} = '0;
        {aEn, bEn, highEn, lowEn, storeEn, wbEn} = '0;
        {immSel, highSel, memSel, wbHighSel, mapSel, storeSel} = '0;
    endtask

    task automatic nextCycle();
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic checkValue(input string name, input word expected, input word actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic loadMem(input regAddr dest, input word data);
        nextCycle();
        memSel = 1'b1;
        wbEn = 1'b1;
        memDataIn = data;
        nextCycle();
        rfWrite = 1'b1;
        addrC = dest;
        modelRegs[dest] = data;
    endtask

    task automatic readCheck(input string name, input regAddr src);
        nextCycle();
        addrB = src;
        #(Period / 4);
        checkValue(name, modelRegs[src], memDataOut);
    endtask

    // Five steps: operands, results, write-back, write, readback
    task automatic aluOperation(input string name, input aluOp op, input regAddr ra,
                                input regAddr rb, input regAddr rd,
                                input logic useImm, input logic wantHigh);
        word immValue;
        product res;
        immValue = nextRandom();
        res = modelAlu(op, modelRegs[ra], useImm ? immValue : modelRegs[rb]);
        nextCycle();
        addrA = ra;
        addrB = rb;
        imm32 = immValue;
        immSel = useImm;
        aEn = 1'b1;
        bEn = 1'b1;
        nextCycle();
        opCode = op;
        highEn = 1'b1;
        lowEn = 1'b1;
        #(Period / 4);
        checkValue("zero flag", word'(res[31:0] == 0), word'(zero));
        checkValue("negative flag", word'(res[31]), word'(negative));
        nextCycle();
        wbEn = 1'b1;
        wbHighSel = wantHigh;
        nextCycle();
        rfWrite = 1'b1;
        addrC = rd;
        modelRegs[rd] = wantHigh ? res[63:32] : res[31:0];
        readCheck(name, rd);
    endtask

    // Op applied twice, the second time on the storage register, low word into the high slot
    task automatic storeOperation(input aluOp op, input regAddr ra, input regAddr rb,
                                  input regAddr rd);
        product res;
        word first;
        res = modelAlu(op, modelRegs[ra], modelRegs[rb]);
        first = res[31:0];
        res = modelAlu(op, first, modelRegs[rb]);
        nextCycle();
        addrA = ra;
        addrB = rb;
        aEn = 1'b1;
        bEn = 1'b1;
        nextCycle();
        opCode = op;
        storeEn = 1'b1;
        nextCycle();
        storeSel = 1'b1;
        highSel = 1'b1;
        highEn = 1'b1;
        nextCycle();
        wbEn = 1'b1;
        wbHighSel = 1'b1;
        nextCycle();
        rfWrite = 1'b1;
        addrC = rd;
        modelRegs[rd] = res[31:0];
        readCheck("stored operand", rd);
    endtask

    // Kind 0 increment, 1 immediate, 2 register, 3 clear, 4 load without enable
    task automatic pcStep(input int kind);
        regAddr src;
        word immValue;
        src = regAddr'(nextRandom());
        immValue = nextRandom();
        if (kind == 2) begin
            nextCycle();
            addrA = src;
            aEn = 1'b1;
        end
        nextCycle();
        imm32 = immValue;
        case (kind)
            0: begin
                pcEn = 1'b1;
                modelPc = modelPc + 1;
            end
            1: begin
                pcEn = 1'b1;
                pcLoadImm = 1'b1;
                modelPc = immValue;
            end
            2: begin
                pcEn = 1'b1;
                pcLoadRa = 1'b1;
                modelPc = modelRegs[src];
            end
            3: begin
                pcClear = 1'b1;
                modelPc = '0;
            end
            default: begin
                pcLoadImm = 1'b1;
            end
        endcase
        nextCycle();
        mapSel = 1'b1;
        #(Period / 4);
        checkValue("program counter", modelPc, memAddr);
    endtask

    task automatic branchCheck(input regAddr src);
        word v;
        v = modelRegs[src];
        nextCycle();
        addrB = src;
        #(Period / 4);
        checkValue("brZero", word'(v == 0), word'(brZero));
        checkValue("brNonZero", word'(v != 0), word'(brNonZero));
        checkValue("brPositive", word'($signed(v) > 0), word'(brPositive));
        checkValue("brNegative", word'($signed(v) < 0), word'(brNegative));
    endtask

    initial begin
        regAddr dest;
        word data;
        logic [3:0] pick;
        clearStrobes();
        rst = 1'b1;
        memDataIn = '0;
        imm32 = '0;
        addrA = '0;
        addrB = '0;
        addrC = '0;
        opCode = opAdd;
        modelRegs = '{default: '0};
        modelPc = '0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;

        // Everything cleared by reset
        for (int r = 0; r < RegCount; r++) begin
            readCheck("reset register", regAddr'(r));
        end
        nextCycle();
        mapSel = 1'b1;
        #(Period / 4);
        checkValue("reset pc", '0, memAddr);

        for (int r = 0; r < RegCount; r++) begin
            loadMem(regAddr'(r), nextRandom());
            readCheck("memory load", regAddr'(r));
        end
        for (int t = 0; t < MemTests; t++) begin
            dest = regAddr'(nextRandom());
            loadMem(dest, nextRandom());
            readCheck("memory load", dest);
        end

        for (int t = 0; t < AluTests; t++) begin
            pick = 4'(nextRandom() % 14);
            aluOperation("alu low word", OpList[pick], regAddr'(nextRandom()),
                         regAddr'(nextRandom()), regAddr'(nextRandom()), 1'b0, 1'b0);
        end
        // Odd iterations take operand B from imm32
        for (int t = 0; t < MulTests; t++) begin
            aluOperation("mul high word", opMul, regAddr'(nextRandom()),
                         regAddr'(nextRandom()), regAddr'(nextRandom()), t[0], 1'b1);
        end
        for (int t = 0; t < StoreTests; t++) begin
            pick = 4'(nextRandom() % 14);
            storeOperation(OpList[pick], regAddr'(nextRandom()), regAddr'(nextRandom()),
                           regAddr'(nextRandom()));
        end

        for (int t = 0; t < PcTests; t++) begin
            pcStep(int'(nextRandom() % 5));
        end
        pcStep(3);

        // Roughly one value in eight forced to zero
        for (int t = 0; t < BranchTests; t++) begin
            dest = regAddr'(nextRandom());
            data = nextRandom();
            if (data[2:0] == 3'b000) begin
                data = '0;
            end
            loadMem(dest, data);
            branchCheck(dest);
        end

        nextCycle();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/wordPkg.sv
verilog/aluPkg.sv
verilog/programCounter.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/datapath.sv
bench/datapath_checker.sv
bench/datapathBench.sv

/* run.sh */
#!/bin/sh
# Build the datapath testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing -f compile.f --top-module datapathBench -o datapathSim \
    && ./obj_dir/datapathSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
